// ==== logic/dcache_settings.svh ====
// Cache geometry macros: number of sets, associativity, address width and line offset width

`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// =========================================================================
// Geometry of the data cache tag store
// =========================================================================

// Number of sets held in every way bank
// The set index width is derived from this value and must stay a power of two
`define DC_LINES 64

// Associativity of the cache
// One tag bank is built for each way
`define DC_WAYS 4

// Width of a byte address as seen by the requester
`define DC_ADDR_BITS 32

// Number of byte offset bits inside one cache line
// A line is therefore 64 bytes wide
`define DC_LOBIT 6

// The tag is whatever remains above the set index and the line offset
// With the values above this gives 32 - 6 - 6 = 20 tag bits

`endif

// ==== logic/dcache_addr_pkg.sv ====
// Address field widths and the address, tag, set index and way number types

`include "dcache_settings.svh"

package dcache_addr_pkg;

	// =====================================================================
	// Field widths
	// =====================================================================

	// Bits needed to select one set
	localparam int DC_INDEX_BITS = $clog2(`DC_LINES);

	// Bits needed to name one way
	localparam int DC_WAY_BITS = $clog2(`DC_WAYS);

	// Lowest address bit that belongs to the tag
	localparam int DC_TAG_LO = `DC_LOBIT + DC_INDEX_BITS;

	// Tag width is the remainder of the address above the set index
	localparam int DC_TAG_BITS = `DC_ADDR_BITS - DC_TAG_LO;

	// =====================================================================
	// Types
	// =====================================================================

	typedef logic [`DC_ADDR_BITS-1:0] dc_addr_t;
	typedef logic [DC_INDEX_BITS-1:0] dc_index_t;
	typedef logic [DC_TAG_BITS-1:0]   dc_tag_t;
	typedef logic [DC_WAY_BITS-1:0]   dc_way_t;

endpackage

// ==== logic/dcache_ctrl_pkg.sv ====
// Operation enum for requests and state enum for the request decoder

`include "dcache_settings.svh"

package dcache_ctrl_pkg;

	// =====================================================================
	// Request operations
	// =====================================================================

	// Lookup reports hit and way, fill writes a victim way, inval drops a line
	typedef enum logic [1:0] {
		dc_op_lookup = 2'd0,
		dc_op_fill   = 2'd1,
		dc_op_inval  = 2'd2
	} dc_op_e;

	// =====================================================================
	// Decoder states
	// =====================================================================

	// The decoder sweeps all sets after reset before it accepts requests
	typedef enum logic {
		dc_st_clear = 1'b0,
		dc_st_ready = 1'b1
	} dc_state_e;

endpackage

// ==== logic/dcache_req_decode.sv ====
// Request decoder: address split, post-reset clearing sweep, round-robin victims, way strobes

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_req_decode (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  dcache_ctrl_pkg::dc_op_e  op,
	input  dcache_addr_pkg::dc_addr_t adr,
	output logic                     ready,
	output dcache_addr_pkg::dc_index_t ndx,
	output dcache_addr_pkg::dc_tag_t req_tag,
	output logic                     look,
	output logic                     inval,
	output logic [`DC_WAYS-1:0]      fill,
	output logic                     clr,
	output dcache_addr_pkg::dc_index_t clr_ndx,
	output logic                     look_q,
	output logic                     fill_q,
	output dcache_addr_pkg::dc_way_t fill_way_q
);
	import dcache_addr_pkg::*;
	import dcache_ctrl_pkg::*;

	dc_state_e state;
	logic      accept;
	logic      fill_en;

	// One victim pointer per set, advanced on every fill to that set
	dc_way_t   victim [`DC_LINES];

	// =====================================================================
	// Address split and request strobes
	// =====================================================================

	assign ndx     = adr[DC_TAG_LO-1:`DC_LOBIT];
	assign req_tag = adr[`DC_ADDR_BITS-1:DC_TAG_LO];

	// Requests are only taken once the sweep has finished
	assign ready  = (state == dc_st_ready);
	assign accept = req & ready;

	assign look    = accept & (op == dc_op_lookup);
	assign inval   = accept & (op == dc_op_inval);
	assign fill_en = accept & (op == dc_op_fill);

	// Only the current victim way of the addressed set gets the fill strobe
	always_comb begin
		fill = '0;
		if (fill_en)
			fill[victim[ndx]] = 1'b1;
	end

	// The banks clear one set per cycle while the sweep runs
	assign clr = (state == dc_st_clear);

	// =====================================================================
	// Sweep state machine and response timing
	// =====================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= dc_st_clear;
			clr_ndx <= '0;
			look_q  <= 1'b0;
			fill_q  <= 1'b0;
		end else begin
			look_q <= look;
			fill_q <= fill_en;
			if (state == dc_st_clear) begin
				clr_ndx <= clr_ndx + 1'b1;
				// Last set cleared, so requests open on the next cycle
				if (clr_ndx == dc_index_t'(`DC_LINES - 1))
					state <= dc_st_ready;
			end
		end
	end

	// =====================================================================
	// Round-robin victim counters
	// =====================================================================

	always_ff @(posedge clk) begin
		if (clr)
			victim[clr_ndx] <= '0;
		else if (fill_en)
			victim[ndx] <= victim[ndx] + 1'b1;
	end

	// The merger reports the way that the fill used, one cycle later
	always_ff @(posedge clk) begin
		fill_way_q <= victim[ndx];
	end

endmodule

// ==== logic/dcache_tag_way.sv ====
// One way bank: tag and valid arrays, registered lookup index, lookup and invalidate compares

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_way (
	input  logic                       clk,
	input  dcache_addr_pkg::dc_index_t ndx,
	input  dcache_addr_pkg::dc_tag_t   req_tag,
	input  logic                       look,
	input  logic                       inval,
	input  logic                       fill,
	input  logic                       clr,
	input  dcache_addr_pkg::dc_index_t clr_ndx,
	output logic                       way_hit
);
	import dcache_addr_pkg::*;

	// Storage for this way, one entry per set
	dc_tag_t   tags  [`DC_LINES];
	logic      valid [`DC_LINES];

	// Index and tag captured by the last lookup
	dc_index_t rndx;
	dc_tag_t   rtag;

	// =====================================================================
	// Array writes
	// =====================================================================

	// A fill only reaches this bank when it is the chosen victim
	always_ff @(posedge clk) begin
		if (fill)
			tags[ndx] <= req_tag;
	end

	// The sweep has priority since the decoder holds off requests meanwhile
	always_ff @(posedge clk) begin
		if (clr)
			valid[clr_ndx] <= 1'b0;
		else if (fill)
			valid[ndx] <= 1'b1;
		else if (inval && tags[ndx] == req_tag)
			valid[ndx] <= 1'b0;
	end

	// =====================================================================
	// Lookup path
	// =====================================================================

	// Hold the lookup address so the compare sees arrays after the edge
	always_ff @(posedge clk) begin
		if (look) begin
			rndx <= ndx;
			rtag <= req_tag;
		end
	end

	// Hit needs a live line whose stored tag equals the looked up tag
	assign way_hit = valid[rndx] && (tags[rndx] == rtag);

endmodule

// ==== logic/dcache_hit_merge.sv ====
// Hit merger: reduces per-way hit bits to one hit flag and way, and forms the response strobe

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_hit_merge (
	input  logic [`DC_WAYS-1:0]      way_hits,
	input  logic                     look_q,
	input  logic                     fill_q,
	input  dcache_addr_pkg::dc_way_t fill_way_q,
	output logic                     resp_valid,
	output logic                     hit,
	output dcache_addr_pkg::dc_way_t resp_way
);
	import dcache_addr_pkg::*;

	logic    any_hit;
	dc_way_t low_way;

	// =====================================================================
	// Way selection
	// =====================================================================

	// Scan from the top so the lowest hitting way is left in low_way
	// With duplicate tags in one set this makes the answer deterministic
	always_comb begin
		low_way = '0;
		for (int i = `DC_WAYS - 1; i >= 0; i--) begin
			if (way_hits[i])
				low_way = dc_way_t'(i);
		end
	end

	assign any_hit = |way_hits;

	// =====================================================================
	// Response
	// =====================================================================

	// Lookups and fills both answer, invalidates stay silent
	assign resp_valid = look_q | fill_q;

	// A fill never reports a hit
	assign hit = look_q & any_hit;

	// Fills report their victim way, lookups the lowest hitting way
	// A miss leaves low_way at zero
	always_comb begin
		if (fill_q)
			resp_way = fill_way_q;
		else if (look_q)
			resp_way = low_way;
		else
			resp_way = '0;
	end

endmodule

// ==== logic/dcache_tag_top.sv ====
// Tag store top level: request decoder, generated way banks and hit merger

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req,
	input  dcache_ctrl_pkg::dc_op_e   op,
	input  dcache_addr_pkg::dc_addr_t adr,
	output logic                      ready,
	output logic                      resp_valid,
	output logic                      hit,
	output dcache_addr_pkg::dc_way_t  resp_way
);
	import dcache_addr_pkg::*;

	// Decoder to bank signals
	dc_index_t           ndx;
	dc_tag_t             req_tag;
	logic                look;
	logic                inval;
	logic [`DC_WAYS-1:0] fill;
	logic                clr;
	dc_index_t           clr_ndx;

	// Signals gathered by the merger
	logic                look_q;
	logic                fill_q;
	dc_way_t             fill_way_q;
	logic [`DC_WAYS-1:0] way_hits;

	// =====================================================================
	// Request decoder
	// =====================================================================

	dcache_req_decode u_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.op         (op),
		.adr        (adr),
		.ready      (ready),
		.ndx        (ndx),
		.req_tag    (req_tag),
		.look       (look),
		.inval      (inval),
		.fill       (fill),
		.clr        (clr),
		.clr_ndx    (clr_ndx),
		.look_q     (look_q),
		.fill_q     (fill_q),
		.fill_way_q (fill_way_q)
	);

	// =====================================================================
	// Way banks
	// =====================================================================

	// Every bank sees the same request, only the fill strobe is per way
	for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
		dcache_tag_way u_way (
			.clk     (clk),
			.ndx     (ndx),
			.req_tag (req_tag),
			.look    (look),
			.inval   (inval),
			.fill    (fill[w]),
			.clr     (clr),
			.clr_ndx (clr_ndx),
			.way_hit (way_hits[w])
		);
	end

	// =====================================================================
	// Hit merger
	// =====================================================================

	dcache_hit_merge u_merge (
		.way_hits   (way_hits),
		.look_q     (look_q),
		.fill_q     (fill_q),
		.fill_way_q (fill_way_q),
		.resp_valid (resp_valid),
		.hit        (hit),
		.resp_way   (resp_way)
	);

endmodule

// ==== sim/dcache_tag_checker.sv ====
// Testbench checker: tag store model, response prediction, per-test report lines and result counts

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_checker (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req,
	input  dcache_ctrl_pkg::dc_op_e   op,
	input  dcache_addr_pkg::dc_addr_t adr,
	input  logic                      ready,
	input  logic                      resp_valid,
	input  logic                      hit,
	input  dcache_addr_pkg::dc_way_t  resp_way,
	input  int                        test_id,
	output int                        n_checks,
	output int                        n_errors
);
	import dcache_addr_pkg::*;
	import dcache_ctrl_pkg::*;

	// Model of the tag store, indexed by way and then by set
	dc_tag_t m_tag    [`DC_WAYS][`DC_LINES];
	logic    m_valid  [`DC_WAYS][`DC_LINES];
	int      m_victim [`DC_LINES];
	// Cycles of the clearing sweep seen so far
	int      clr_cnt;

	// Response owed for the request accepted in the previous cycle
	logic    p_valid;
	int      p_id;
	int      p_hit;
	int      p_way;

	int      cur_id;
	int      t_checks;
	int      t_errors;

	function automatic string name_of(input int id);
		case (id)
			1: return "clearing";
			2: return "fill_lookup";
			3: return "round_robin";
			4: return "invalidate";
			5: return "random_mix";
			default: return "idle";
		endcase
	endfunction

	task automatic compare(input int id, input string what, input int exp, input int act);
		n_checks++;
		t_checks++;
		if (exp != act) begin
			n_errors++;
			t_errors++;
			$display("MISMATCH %0s %0s: expected %0d, actual %0d", name_of(id), what, exp, act);
		end
	endtask

	task automatic fault(input string msg);
		n_errors++;
		t_errors++;
		$display("ERROR in %0s: %0s", name_of(cur_id), msg);
	endtask

	// =========================================================================
	// Per-cycle model update and comparison
	// =========================================================================

	always @(posedge clk) begin : watch
		dc_index_t set;
		dc_tag_t   tag;
		int        exp_ready;
		// Line offset is the low field, the set index sits above it, the tag is the rest
		set = adr[`DC_LOBIT +: DC_INDEX_BITS];
		tag = adr[`DC_ADDR_BITS-1 -: DC_TAG_BITS];
		if (!rst_n) begin
			m_valid  = '{default: '{default: 1'b0}};
			m_victim = '{default: 0};
			clr_cnt  = 0;
			p_valid  = 1'b0;
			cur_id   = 0;
			n_checks = 0;
			n_errors = 0;
		end else begin
			// A change of test number closes the previous test
			if (test_id != cur_id) begin
				if (cur_id != 0)
					$display("Test %0s done: %0d checks, %0d errors",
						name_of(cur_id), t_checks, t_errors);
				cur_id   = test_id;
				t_checks = 0;
				t_errors = 0;
			end
			// Requests open once every set has had one sweep cycle
			exp_ready = (clr_cnt >= `DC_LINES) ? 1 : 0;
			if (exp_ready == 0)
				clr_cnt++;
			compare(cur_id, "ready", exp_ready, int'(ready));
			if (p_valid && !resp_valid)
				fault("no response came for the lookup or fill of the previous cycle");
			else if (!p_valid && resp_valid)
				fault("resp_valid was high although no lookup or fill was accepted");
			else if (p_valid) begin
				compare(p_id, "hit", p_hit, int'(hit));
				compare(p_id, "resp_way", p_way, int'(resp_way));
			end
			p_valid = 1'b0;
			// Dropped requests leave the model untouched
			if (req && exp_ready == 1) begin
				p_id  = cur_id;
				p_hit = 0;
				p_way = 0;
				case (op)
					dc_op_lookup: begin
						p_valid = 1'b1;
						// Lowest matching way wins, a miss reports way 0
						for (int w = 0; w < `DC_WAYS; w++) begin
							if (p_hit == 0 && m_valid[w][set] && m_tag[w][set] == tag) begin
								p_hit = 1;
								p_way = w;
							end
						end
					end
					dc_op_fill: begin
						p_valid = 1'b1;
						p_way   = m_victim[set];
						m_tag[p_way][set]   = tag;
						m_valid[p_way][set] = 1'b1;
						m_victim[set] = (m_victim[set] + 1) % `DC_WAYS;
					end
					dc_op_inval: begin
						for (int w = 0; w < `DC_WAYS; w++) begin
							if (m_tag[w][set] == tag)
								m_valid[w][set] = 1'b0;
						end
					end
					default: fault("a request carried an undefined operation code");
				endcase
			end
		end
	end

endmodule

// ==== sim/dcache_tag_tb.sv ====
// Testbench top: clock, reset, LCG stimulus, test sequence, timeout and closing summary

`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_tag_tb;
	import dcache_addr_pkg::*;
	import dcache_ctrl_pkg::*;

	// Requests issued by each test, the timeout is derived from their sum
	localparam int N_CLEAR  = 24;
	localparam int N_FILL   = 24;
	localparam int N_RR     = 10;
	localparam int N_INVAL  = 9;
	localparam int N_RANDOM = 300;
	localparam int N_TOTAL  = N_CLEAR + N_FILL + N_RR + N_INVAL + N_RANDOM;
	localparam int TIMEOUT_CYCLES = `DC_LINES + 2 * N_TOTAL + 100;

	logic        clk;
	logic        rst_n;
	logic        req;
	dc_op_e      op;
	dc_addr_t    adr;
	logic        ready;
	logic        resp_valid;
	logic        hit;
	dc_way_t     resp_way;
	int          test_id;
	int          n_checks;
	int          n_errors;
	int          cycle_cnt;
	logic [31:0] lcg_state;
	dc_tag_t     pool [6];

	dcache_tag_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.op         (op),
		.adr        (adr),
		.ready      (ready),
		.resp_valid (resp_valid),
		.hit        (hit),
		.resp_way   (resp_way)
	);

	dcache_tag_checker u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.op         (op),
		.adr        (adr),
		.ready      (ready),
		.resp_valid (resp_valid),
		.hit        (hit),
		.resp_way   (resp_way),
		.test_id    (test_id),
		.n_checks   (n_checks),
		.n_errors   (n_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Low state bits of an LCG repeat quickly, so only the upper bits are handed out
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	function automatic dc_op_e op_of(input int k);
		case (k)
			0: return dc_op_lookup;
			1: return dc_op_fill;
			default: return dc_op_inval;
		endcase
	endfunction

	// One request strobe with a random line offset, entered and left 2 ns after an edge
	task automatic send(input dc_op_e o, input dc_tag_t tag, input dc_index_t set);
		logic [31:0] r;
		r   = lcg_next();
		req = 1'b1;
		op  = o;
		adr = {tag, set, r[`DC_LOBIT-1:0]};
		@(posedge clk);
		#2;
		req = 1'b0;
	endtask

	// Let the last response reach the checker before the test number moves on
	task automatic next_test(input int id);
		repeat (2) @(posedge clk);
		#2;
		test_id = id;
	endtask

	// =========================================================================
	// Timeout
	// =========================================================================

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// =========================================================================
	// Test sequence
	// =========================================================================

	initial begin : stimulus
		dc_tag_t   tag;
		dc_index_t set;
		int        k;
		int        j;
		rst_n     = 1'b0;
		req       = 1'b0;
		op        = dc_op_lookup;
		adr       = '0;
		test_id   = 1;
		lcg_state = 32'd82;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// Requests during the sweep must vanish, afterwards every line misses
		for (int i = 0; i < 8; i++) begin
			tag = dc_tag_t'(lcg_next());
			set = dc_index_t'(lcg_next());
			send(op_of(i % 3), tag, set);
		end
		while (!ready) begin
			@(posedge clk);
			#2;
		end
		for (int i = 0; i < 16; i++) begin
			tag = dc_tag_t'(lcg_next());
			set = dc_index_t'(lcg_next());
			send(dc_op_lookup, tag, set);
		end

		// Fill then look up the same line and a neighbour tag in sets 0 to 31
		next_test(2);
		for (int i = 0; i < 8; i++) begin
			tag = dc_tag_t'(lcg_next());
			set = dc_index_t'(lcg_next() % 32);
			send(dc_op_fill, tag, set);
			send(dc_op_lookup, tag, set);
			send(dc_op_lookup, tag ^ dc_tag_t'(1), set);
		end

		// Set 40 is still untouched, so its victims start at way 0
		next_test(3);
		set = dc_index_t'(40);
		for (int i = 0; i < 5; i++)
			send(dc_op_fill, dc_tag_t'(32'hA000 + i), set);
		for (int i = 0; i < 5; i++)
			send(dc_op_lookup, dc_tag_t'(32'hA000 + i), set);

		next_test(4);
		set = dc_index_t'(50);
		for (int i = 0; i < 4; i++)
			send(dc_op_fill, dc_tag_t'(32'hB000 + i), set);
		send(dc_op_inval, dc_tag_t'(32'hB001), set);
		for (int i = 0; i < 4; i++)
			send(dc_op_lookup, dc_tag_t'(32'hB000 + i), set);

		// A pool of six tags over four sets keeps hits and duplicates frequent
		next_test(5);
		for (int i = 0; i < 6; i++)
			pool[i] = dc_tag_t'(lcg_next());
		for (int i = 0; i < N_RANDOM; i++) begin
			k   = int'(lcg_next() % 3);
			j   = int'(lcg_next() % 6);
			set = dc_index_t'(lcg_next() % 4);
			send(op_of(k), pool[j], set);
		end

		next_test(0);
		repeat (2) @(posedge clk);
		#2;
		$display("Totals: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0 && n_checks > 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+logic
logic/dcache_addr_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_req_decode.sv
logic/dcache_tag_way.sv
logic/dcache_hit_merge.sv
logic/dcache_tag_top.sv
sim/dcache_tag_checker.sv
sim/dcache_tag_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the tag store testbench with Verilator, runs it and scans the log for the verdict

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module dcache_tag_tb -f files.f -o dcache_tag_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/dcache_tag_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation run exited with status $run_status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

exit 0
